//--- Bender.yml
package:
  name: atop_resolver

sources:
  - files:
      - verilog/atop_pkg.sv
      - verilog/amo_alu.sv
      - verilog/lrsc_reservation.sv
      - verilog/amo_sequencer.sv
      - verilog/rsp_buffer.sv
      - verilog/atop_resolver.sv
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_atop_resolver.sv

//--- sim.f
verilog/atop_pkg.sv
verilog/amo_alu.sv
verilog/lrsc_reservation.sv
verilog/amo_sequencer.sv
verilog/rsp_buffer.sv
verilog/atop_resolver.sv
test/tb_mem_model.sv
test/tb_atop_resolver.sv

//--- test/tb_atop_resolver.sv
/*
 * Testbench of the atomic-operation resolver.
 * Drives plain, AMO and LR/SC traffic, predicts every response from a
 * shadow memory and reservation and checks the responses in order.
 */
module tb_atop_resolver;

  localparam int ClkPeriod   = 40;
  localparam int DriveDelay  = 5;
  localparam int ResetCycles = 5;
  localparam int Words       = 16;
  localparam int NumAmoPairs = 2;
  localparam int NumMixOps   = 200;
  // Plain test, nine AMOs with write and read around each, LR/SC pass and fail
  localparam int NumOps = 2 * Words + 9 * NumAmoPairs * 3 + 4 + 5 + NumMixOps;

  localparam atop_pkg::atop_e AmoOps [9] = '{
    atop_pkg::AMO_SWAP, atop_pkg::AMO_ADD, atop_pkg::AMO_XOR,
    atop_pkg::AMO_AND, atop_pkg::AMO_OR, atop_pkg::AMO_MIN,
    atop_pkg::AMO_MAX, atop_pkg::AMO_MINU, atop_pkg::AMO_MAXU
  };
  // Memory and operand pairs on the signed and unsigned boundaries
  localparam atop_pkg::data_t AmoMem [NumAmoPairs] = '{32'h8000_0000, 32'h7fff_ffff};
  localparam atop_pkg::data_t AmoVal [NumAmoPairs] = '{32'h0000_0001, 32'hffff_ffff};

  typedef struct packed {
    atop_pkg::bus_r_t r;
    logic             has_data;
  } expect_t;

  logic             clk_i;
  logic             rst_ni;
  logic             req;
  atop_pkg::bus_a_t a_req;
  logic             gnt;
  logic             rvalid;
  atop_pkg::bus_r_t rsp;
  logic             rready;
  logic             mem_req;
  atop_pkg::mem_a_t mem_a;
  logic             mem_gnt;
  logic             mem_rvalid;
  atop_pkg::mem_r_t mem_r;

  atop_pkg::data_t  shadow_mem [Words];
  logic             resv_valid;
  atop_pkg::addr_t  resv_addr;
  atop_pkg::id_t    resv_id;
  expect_t          exp_q [$];
  logic [31:0]      lfsr_q;
  logic             rand_ready;
  string            test_name;
  int               errors;
  int               checks;
  int               tests_run;
  int               ops_done;
  int               err_start;
  int               ops_start;

  atop_resolver #(
    .LrScEnable(1'b1),
    .BufDepth  (2)
  ) UUT (
    .clk_i,
    .rst_ni,
    .req_i       (req),
    .a_i         (a_req),
    .gnt_o       (gnt),
    .rvalid_o    (rvalid),
    .r_o         (rsp),
    .rready_i    (rready),
    .mem_req_o   (mem_req),
    .mem_a_o     (mem_a),
    .mem_gnt_i   (mem_gnt),
    .mem_rvalid_i(mem_rvalid),
    .mem_r_i     (mem_r)
  );

  tb_mem_model #(
    .Words(Words)
  ) i_mem (
    .clk_i,
    .rst_ni,
    .req_i   (mem_req),
    .a_i     (mem_a),
    .gnt_o   (mem_gnt),
    .rvalid_o(mem_rvalid),
    .r_o     (mem_r)
  );

  // ---------------------------------------------------------------------
  // Random numbers and the reference model
  // ---------------------------------------------------------------------

  // Taps 32, 22, 2 and 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic atop_pkg::data_t merge_bytes(input atop_pkg::data_t old,
      input atop_pkg::data_t wdata, input atop_pkg::be_t be);
    atop_pkg::data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Value written back by an AMO, by the RISC-V A extension
  function automatic atop_pkg::data_t amo_result(input atop_pkg::atop_e op,
      input atop_pkg::data_t old, input atop_pkg::data_t val);
    case (op)
      atop_pkg::AMO_SWAP: return val;
      atop_pkg::AMO_ADD:  return old + val;
      atop_pkg::AMO_XOR:  return old ^ val;
      atop_pkg::AMO_AND:  return old & val;
      atop_pkg::AMO_OR:   return old | val;
      atop_pkg::AMO_MIN:  return ($signed(old) < $signed(val)) ? old : val;
      atop_pkg::AMO_MAX:  return ($signed(old) > $signed(val)) ? old : val;
      atop_pkg::AMO_MINU: return (old < val) ? old : val;
      atop_pkg::AMO_MAXU: return (old > val) ? old : val;
      default:            return old;
    endcase
  endfunction

  // Applies one granted request to the shadow state, returns its response
  function automatic expect_t reference(input atop_pkg::bus_a_t a);
    expect_t     e;
    int unsigned idx;
    logic        owner;
    logic        hit;
    logic        is_amo;
    idx    = a.addr[5:2];
    owner  = resv_valid && (resv_id == a.aid);
    hit    = resv_valid && (resv_addr == a.addr);
    is_amo = a.atop[5] && (a.atop != atop_pkg::ATOP_LR) && (a.atop != atop_pkg::ATOP_SC);
    e.r.rdata  = shadow_mem[idx];
    e.r.err    = 1'b0;
    e.r.exokay = 1'b0;
    e.r.rid    = a.aid;
    e.has_data = 1'b1;
    if (a.atop == atop_pkg::ATOP_LR) begin
      // Another requester's live reservation is left alone
      if (!resv_valid || owner) begin
        resv_valid = 1'b1;
        resv_addr  = a.addr;
        resv_id    = a.aid;
        e.r.exokay = 1'b1;
      end
    end else if (a.atop == atop_pkg::ATOP_SC) begin
      e.r.rdata = (owner && hit) ? 32'd0 : 32'd1;
      if (owner && hit) begin
        shadow_mem[idx] = merge_bytes(shadow_mem[idx], a.wdata, a.be);
        e.r.exokay      = 1'b1;
      end
      if (owner) begin
        resv_valid = 1'b0;
      end
    end else if (is_amo || a.we) begin
      if (hit && (resv_id != a.aid)) begin
        resv_valid = 1'b0;
      end
      if (is_amo) begin
        shadow_mem[idx] = amo_result(a.atop, shadow_mem[idx], a.wdata);
      end else begin
        shadow_mem[idx] = merge_bytes(shadow_mem[idx], a.wdata, a.be);
        e.has_data      = 1'b0;
      end
    end
    return e;
  endfunction

  // ---------------------------------------------------------------------
  // Compare tasks
  // ---------------------------------------------------------------------

  task automatic check_data(input string what, input atop_pkg::data_t exp,
      input atop_pkg::data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_id(input string what, input atop_pkg::id_t exp,
      input atop_pkg::id_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // ---------------------------------------------------------------------
  // Request driving
  // ---------------------------------------------------------------------

  function automatic atop_pkg::bus_a_t make_req(input atop_pkg::atop_e op, input logic we,
      input int unsigned word, input atop_pkg::data_t wdata, input atop_pkg::be_t be,
      input atop_pkg::id_t id);
    atop_pkg::bus_a_t a;
    a.addr  = atop_pkg::addr_t'(word << 2);
    a.we    = we;
    a.be    = be;
    a.wdata = wdata;
    a.aid   = id;
    a.atop  = op;
    return a;
  endfunction

  // Called a drive delay after a rising edge, returns at the same point
  task automatic issue(input atop_pkg::bus_a_t a);
    req   = 1'b1;
    a_req = a;
    @(negedge clk_i);
    while (!gnt) begin
      @(negedge clk_i);
    end
    exp_q.push_back(reference(a));
    ops_done++;
    @(posedge clk_i);
    #(DriveDelay);
    req = 1'b0;
  endtask

  task automatic write_word(input int unsigned word, input atop_pkg::data_t wdata,
      input atop_pkg::be_t be, input atop_pkg::id_t id);
    issue(make_req(atop_pkg::ATOP_NONE, 1'b1, word, wdata, be, id));
  endtask

  task automatic read_word(input int unsigned word, input atop_pkg::id_t id);
    issue(make_req(atop_pkg::ATOP_NONE, 1'b0, word, '0, 4'hf, id));
  endtask

  task automatic atomic(input atop_pkg::atop_e op, input int unsigned word,
      input atop_pkg::data_t wdata, input atop_pkg::id_t id);
    issue(make_req(op, 1'b0, word, wdata, 4'hf, id));
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = errors;
    ops_start = ops_done;
  endtask

  // Waits until every granted request has been answered
  task automatic finish_test();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
    #(DriveDelay);
    tests_run++;
    $display("test %s: %0d operations, %0d errors", test_name, ops_done - ops_start,
             errors - err_start);
  endtask

  // ---------------------------------------------------------------------
  // Processes
  // ---------------------------------------------------------------------

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin : ready_drive
    logic [31:0] bits;
    forever begin
      @(posedge clk_i);
      bits = 32'd1;
      if (rand_ready) begin
        bits = rand_bits(1);
      end
      #(DriveDelay);
      rready = bits[0];
    end
  end

  initial begin : compare
    expect_t e;
    forever begin
      @(negedge clk_i);
      if (rst_ni && rvalid && rready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("response in test %s arrived with no request outstanding", test_name);
        end else begin
          e = exp_q.pop_front();
          if (e.has_data) begin
            check_data("rdata", e.r.rdata, rsp.rdata);
          end
          check_flag("err", e.r.err, rsp.err);
          check_flag("exokay", e.r.exokay, rsp.exokay);
          check_id("rid", e.r.rid, rsp.rid);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (ResetCycles + NumOps * 20) @(posedge clk_i);
    $display("timeout in test %s, the run did not finish in %0d cycles", test_name,
             ResetCycles + NumOps * 20);
    $display("tests failed");
    $finish;
  end

  initial begin : main
    int unsigned   word;
    int unsigned   sel;
    atop_pkg::id_t id;
    atop_pkg::data_t wdata;
    rst_ni     = 1'b0;
    req        = 1'b0;
    a_req      = '0;
    rready     = 1'b0;
    rand_ready = 1'b0;
    lfsr_q     = 32'h416a_b524;
    resv_valid = 1'b0;
    resv_addr  = '0;
    resv_id    = '0;
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    ops_done   = 0;
    test_name  = "reset";
    repeat (ResetCycles) @(posedge clk_i);
    #(DriveDelay);
    rst_ni = 1'b1;

    // Every word is written in full before anything reads it
    start_test("plain_rw");
    for (int w = 0; w < Words; w++) begin
      write_word(w, rand_bits(32), 4'hf, atop_pkg::id_t'(w));
    end
    for (int w = 0; w < Words; w++) begin
      read_word(w, atop_pkg::id_t'(w + 1));
    end
    finish_test();

    start_test("amo");
    for (int i = 0; i < 9; i++) begin
      for (int p = 0; p < NumAmoPairs; p++) begin
        write_word(i, AmoMem[p], 4'hf, 4'd1);
        atomic(AmoOps[i], i, AmoVal[p], 4'd2);
        read_word(i, 4'd3);
      end
    end
    finish_test();

    start_test("lr_sc_pass");
    write_word(5, 32'h1111_2222, 4'hf, 4'd1);
    atomic(atop_pkg::ATOP_LR, 5, '0, 4'd4);
    atomic(atop_pkg::ATOP_SC, 5, 32'hcafe_f00d, 4'd4);
    read_word(5, 4'd4);
    finish_test();

    // A store from id 7 breaks the reservation of id 6
    start_test("lr_sc_broken");
    write_word(7, 32'h3333_4444, 4'hf, 4'd1);
    atomic(atop_pkg::ATOP_LR, 7, '0, 4'd6);
    write_word(7, 32'h5555_6666, 4'hf, 4'd7);
    atomic(atop_pkg::ATOP_SC, 7, 32'hdead_beef, 4'd6);
    read_word(7, 4'd6);
    finish_test();

    // Few words and ids so that reservations collide often
    start_test("random_mix");
    rand_ready = 1'b1;
    for (int n = 0; n < NumMixOps; n++) begin
      sel   = rand_bits(4) % 13;
      word  = rand_bits(2);
      id    = atop_pkg::id_t'(rand_bits(2));
      wdata = rand_bits(32);
      if (rand_bits(1) != 0) begin
        @(posedge clk_i);
        #(DriveDelay);
      end
      case (sel)
        0:       read_word(word, id);
        1:       write_word(word, wdata, atop_pkg::be_t'(rand_bits(4)), id);
        2:       atomic(atop_pkg::ATOP_LR, word, wdata, id);
        3:       atomic(atop_pkg::ATOP_SC, word, wdata, id);
        default: atomic(AmoOps[sel-4], word, wdata, id);
      endcase
    end
    finish_test();
    rand_ready = 1'b0;

    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- test/tb_mem_model.sv
/*
 * Behavioral single-port memory for the testbench.
 * Grants every request and answers one cycle later with the addressed
 * word and the request id.
 */
module tb_mem_model #(
  parameter int unsigned Words = 16
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  atop_pkg::mem_a_t a_i,
  output logic             gnt_o,
  output logic             rvalid_o,
  output atop_pkg::mem_r_t r_o
);

  localparam int unsigned IdxWidth = $clog2(Words);

  atop_pkg::data_t     mem_q [Words];
  logic [IdxWidth-1:0] idx;

  assign gnt_o = 1'b1;
  assign idx   = a_i.addr[IdxWidth+1:2];

  // Start-up contents follow the byte address of each word
  initial begin
    for (int i = 0; i < Words; i++) begin
      mem_q[i] = 32'hc0de_0000 | 32'(i << 2);
    end
  end

  // The read sees the word before a write in the same cycle
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
      r_o      <= '0;
    end else begin
      rvalid_o <= req_i & gnt_o;
      if (req_i && gnt_o) begin
        r_o.rdata <= mem_q[idx];
        r_o.err   <= 1'b0;
        r_o.rid   <= a_i.aid;
        if (a_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (a_i.be[b]) begin
              mem_q[idx][8*b +: 8] <= a_i.wdata[8*b +: 8];
            end
          end
        end
      end
    end
  end

endmodule

//--- verilog/amo_alu.sv
/*
 * Combinational ALU for the read-modify-write atomics.
 * One 33-bit adder serves ADD and the signed and unsigned MIN/MAX compares.
 */
module amo_alu (
  input  atop_pkg::atop_e op_i,
  input  atop_pkg::data_t mem_i,
  input  atop_pkg::data_t operand_i,
  output atop_pkg::data_t result_o
);

  localparam int unsigned W = atop_pkg::DataWidth;

  logic         is_signed;
  logic         is_cmp;
  logic         mem_lt;
  logic [W:0]   opa;
  logic [W:0]   opb;
  logic [W:0]   sum;

  assign is_signed = (op_i == atop_pkg::AMO_MIN) || (op_i == atop_pkg::AMO_MAX);
  assign is_cmp    = is_signed || (op_i == atop_pkg::AMO_MINU) ||
                     (op_i == atop_pkg::AMO_MAXU);

  // The extra top bit is the sign for signed compares and zero otherwise
  assign opa = {is_signed & mem_i[W-1], mem_i};
  assign opb = {is_signed & operand_i[W-1], operand_i};

  // Compares subtract, so the top bit of the sum says memory is the smaller value
  assign sum    = opa + (is_cmp ? ~opb : opb) + {{W{1'b0}}, is_cmp};
  assign mem_lt = sum[W];

  always_comb begin
    unique case (op_i)
      atop_pkg::AMO_SWAP:               result_o = operand_i;
      atop_pkg::AMO_ADD:                result_o = sum[W-1:0];
      atop_pkg::AMO_XOR:                result_o = mem_i ^ operand_i;
      atop_pkg::AMO_AND:                result_o = mem_i & operand_i;
      atop_pkg::AMO_OR:                 result_o = mem_i | operand_i;
      atop_pkg::AMO_MIN, atop_pkg::AMO_MINU: begin
        result_o = mem_lt ? mem_i : operand_i;
      end
      atop_pkg::AMO_MAX, atop_pkg::AMO_MAXU: begin
        result_o = mem_lt ? operand_i : mem_i;
      end
      default:                          result_o = '0;
    endcase
  end

endmodule

//--- verilog/amo_sequencer.sv
/*
 * Request sequencer of the resolver.
 * Forwards plain accesses and LR/SC, and splits each AMO into a read
 * followed by a full-word write-back of the ALU result.
 */
module amo_sequencer (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  atop_pkg::bus_a_t a_i,
  output logic             gnt_o,
  input  logic             room_i,
  input  logic             sc_pass_i,
  output logic             mem_req_o,
  output atop_pkg::mem_a_t mem_a_o,
  input  logic             mem_gnt_i,
  input  logic             mem_rvalid_i,
  input  atop_pkg::data_t  mem_rdata_i,
  output atop_pkg::atop_e  alu_op_o,
  output atop_pkg::data_t  alu_mem_o,
  output atop_pkg::data_t  alu_operand_o,
  input  atop_pkg::data_t  alu_result_i,
  output logic             push_o
);

  typedef enum logic {
    ST_IDLE,
    ST_DO_AMO
  } amo_state_e;

  amo_state_e      state_q;
  amo_state_e      state_d;
  atop_pkg::atop_e op_q;
  atop_pkg::addr_t addr_q;
  atop_pkg::id_t   aid_q;
  atop_pkg::data_t operand_q;
  atop_pkg::data_t rdata_q;
  logic            rd_done_q;
  logic            rd_done_d;
  logic            wb_q;
  logic            is_amo;
  logic            load_amo;
  logic            wb_issue;

  assign is_amo = a_i.atop[5] && (a_i.atop != atop_pkg::ATOP_LR) &&
                  (a_i.atop != atop_pkg::ATOP_SC);

  // Read data is used as it arrives, or from the register while the write-back waits
  assign alu_op_o      = op_q;
  assign alu_operand_o = operand_q;
  assign alu_mem_o     = mem_rvalid_i ? mem_rdata_i : rdata_q;

  // The response to a write-back is dropped
  assign push_o = !wb_q;

  // ---------------------------------------------------------------------
  // Request steering
  // ---------------------------------------------------------------------

  always_comb begin
    state_d       = state_q;
    load_amo      = 1'b0;
    wb_issue      = 1'b0;
    gnt_o         = room_i & mem_gnt_i;
    mem_req_o     = req_i & room_i;
    mem_a_o.addr  = a_i.addr;
    mem_a_o.we    = a_i.we;
    mem_a_o.be    = a_i.be;
    mem_a_o.wdata = a_i.wdata;
    mem_a_o.aid   = a_i.aid;
    if (a_i.atop == atop_pkg::ATOP_SC) begin
      mem_a_o.we = sc_pass_i;
    end else if (is_amo) begin
      mem_a_o.we = 1'b0;
    end

    unique case (state_q)
      ST_IDLE: begin
        if (req_i && gnt_o && is_amo) begin
          load_amo = 1'b1;
          state_d  = ST_DO_AMO;
        end
      end
      ST_DO_AMO: begin
        gnt_o         = 1'b0;
        mem_req_o     = mem_rvalid_i | rd_done_q;
        mem_a_o.addr  = addr_q;
        mem_a_o.we    = 1'b1;
        mem_a_o.be    = '1;
        mem_a_o.wdata = alu_result_i;
        mem_a_o.aid   = aid_q;
        if (mem_req_o && mem_gnt_i) begin
          wb_issue = 1'b1;
          state_d  = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  assign rd_done_d = (state_q == ST_DO_AMO) && (mem_rvalid_i || rd_done_q) && !wb_issue;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      rd_done_q <= 1'b0;
      wb_q      <= 1'b0;
    end else begin
      state_q   <= state_d;
      rd_done_q <= rd_done_d;
      wb_q      <= wb_issue;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      op_q      <= a_i.atop;
      addr_q    <= a_i.addr;
      aid_q     <= a_i.aid;
      operand_q <= a_i.wdata;
    end
    if ((state_q == ST_DO_AMO) && mem_rvalid_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

endmodule

//--- verilog/atop_pkg.sv
/*
 * Shared definitions of the atomic-operation resolver.
 * Word, address and id widths with their vector types, the RISC-V atomic
 * opcode encoding and the packed request and response structs.
 */
package atop_pkg;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned IdWidth   = 4;

  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth/8-1:0] be_t;
  typedef logic [IdWidth-1:0]     id_t;

  // Bit 5 marks an atomic, the low bits follow the RISC-V funct5 field
  typedef enum logic [5:0] {
    ATOP_NONE = 6'h00,
    AMO_ADD   = 6'h20,
    AMO_SWAP  = 6'h21,
    ATOP_LR   = 6'h22,
    ATOP_SC   = 6'h23,
    AMO_XOR   = 6'h24,
    AMO_OR    = 6'h28,
    AMO_AND   = 6'h2C,
    AMO_MIN   = 6'h30,
    AMO_MAX   = 6'h34,
    AMO_MINU  = 6'h38,
    AMO_MAXU  = 6'h3C
  } atop_e;

  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
    id_t   aid;
    atop_e atop;
  } bus_a_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
    logic  exokay;
    id_t   rid;
  } bus_r_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
    id_t   aid;
  } mem_a_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
    id_t   rid;
  } mem_r_t;

endpackage

//--- verilog/atop_resolver.sv
/*
 * Atomic-operation resolver in front of a single-port memory.
 * Connects the sequencer, LR/SC reservation, AMO ALU and response buffer.
 */
module atop_resolver #(
  parameter bit LrScEnable = 1'b1,
  parameter int BufDepth   = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  atop_pkg::bus_a_t a_i,
  output logic             gnt_o,
  output logic             rvalid_o,
  output atop_pkg::bus_r_t r_o,
  input  logic             rready_i,
  output logic             mem_req_o,
  output atop_pkg::mem_a_t mem_a_o,
  input  logic             mem_gnt_i,
  input  logic             mem_rvalid_i,
  input  atop_pkg::mem_r_t mem_r_i
);

  logic            room;
  logic            push;
  logic            accept;
  logic            sc_pass;
  logic            sc_q;
  logic            lr_sc_ok_q;
  atop_pkg::atop_e alu_op;
  atop_pkg::data_t alu_mem;
  atop_pkg::data_t alu_operand;
  atop_pkg::data_t alu_result;

  assign accept = req_i & gnt_o;

  amo_sequencer i_sequencer (
    .clk_i,
    .rst_ni,
    .req_i,
    .a_i,
    .gnt_o,
    .room_i       (room),
    .sc_pass_i    (sc_pass),
    .mem_req_o,
    .mem_a_o,
    .mem_gnt_i,
    .mem_rvalid_i,
    .mem_rdata_i  (mem_r_i.rdata),
    .alu_op_o     (alu_op),
    .alu_mem_o    (alu_mem),
    .alu_operand_o(alu_operand),
    .alu_result_i (alu_result),
    .push_o       (push)
  );

  // ---------------------------------------------------------------------
  // LR/SC, without it an SC goes to memory as a plain read
  // ---------------------------------------------------------------------

  if (LrScEnable) begin : gen_lrsc
    lrsc_reservation i_reservation (
      .clk_i,
      .rst_ni,
      .accept_i    (accept),
      .a_i,
      .sc_pass_o   (sc_pass),
      .sc_q_o      (sc_q),
      .lr_sc_ok_q_o(lr_sc_ok_q)
    );
  end else begin : gen_no_lrsc
    assign sc_pass    = 1'b0;
    assign sc_q       = 1'b0;
    assign lr_sc_ok_q = 1'b0;
  end

  amo_alu i_alu (
    .op_i     (alu_op),
    .mem_i    (alu_mem),
    .operand_i(alu_operand),
    .result_o (alu_result)
  );

  rsp_buffer #(
    .BufDepth(BufDepth)
  ) i_rsp_buffer (
    .clk_i,
    .rst_ni,
    .push_i      (push),
    .mem_rvalid_i,
    .mem_r_i,
    .sc_q_i      (sc_q),
    .lr_sc_ok_q_i(lr_sc_ok_q),
    .rvalid_o,
    .r_o,
    .rready_i,
    .issue_i     (accept),
    .room_o      (room)
  );

endmodule

//--- verilog/lrsc_reservation.sv
/*
 * Load-reserved / store-conditional tracking.
 * Holds one reservation, decides whether an SC may write and registers
 * the SC and success flags that go with the next memory response.
 */
module lrsc_reservation (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             accept_i,
  input  atop_pkg::bus_a_t a_i,
  output logic             sc_pass_o,
  output logic             sc_q_o,
  output logic             lr_sc_ok_q_o
);

  typedef struct packed {
    logic            valid;
    atop_pkg::addr_t addr;
    atop_pkg::id_t   rid;
  } resv_t;

  resv_t resv_q;
  resv_t resv_d;
  logic  is_lr;
  logic  is_sc;
  logic  is_amo;
  logic  other_id;
  logic  addr_hit;
  logic  ok_d;

  assign is_lr    = (a_i.atop == atop_pkg::ATOP_LR);
  assign is_sc    = (a_i.atop == atop_pkg::ATOP_SC);
  assign is_amo   = a_i.atop[5] && !is_lr && !is_sc;
  assign other_id = (a_i.aid != resv_q.rid);
  assign addr_hit = (a_i.addr == resv_q.addr);

  // Only the owner of a live reservation on the same word may store
  assign sc_pass_o = is_sc && resv_q.valid && !other_id && addr_hit;

  always_comb begin
    resv_d = resv_q;
    ok_d   = 1'b0;
    if (accept_i) begin
      // A live reservation of another requester is kept, so no one starves
      if (is_lr && (!resv_q.valid || !other_id)) begin
        resv_d.valid = 1'b1;
        resv_d.addr  = a_i.addr;
        resv_d.rid   = a_i.aid;
        ok_d         = 1'b1;
      end
      if (other_id && addr_hit && ((a_i.we && !is_sc) || is_amo)) begin
        resv_d.valid = 1'b0;
      end
      if (is_sc && resv_q.valid && !other_id) begin
        resv_d.valid = 1'b0;
        ok_d         = addr_hit;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resv_q       <= '0;
      sc_q_o       <= 1'b0;
      lr_sc_ok_q_o <= 1'b0;
    end else begin
      resv_q       <= resv_d;
      sc_q_o       <= accept_i && is_sc;
      lr_sc_ok_q_o <= ok_d;
    end
  end

endmodule

//--- verilog/rsp_buffer.sv
/*
 * Fall-through response FIFO towards the requester.
 * Inserts the SC result and exokay flag and reports room for one more
 * request, counting the memory access still in flight.
 */
module rsp_buffer #(
  parameter int BufDepth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic             mem_rvalid_i,
  input  atop_pkg::mem_r_t mem_r_i,
  input  logic             sc_q_i,
  input  logic             lr_sc_ok_q_i,
  output logic             rvalid_o,
  output atop_pkg::bus_r_t r_o,
  input  logic             rready_i,
  input  logic             issue_i,
  output logic             room_o
);

  localparam int PtrWidth = (BufDepth > 1) ? $clog2(BufDepth) : 1;
  localparam int CntWidth = $clog2(BufDepth + 1);

  atop_pkg::bus_r_t    entries_q [BufDepth];
  atop_pkg::bus_r_t    in_entry;
  logic [PtrWidth-1:0] wptr_q;
  logic [PtrWidth-1:0] rptr_q;
  logic [CntWidth-1:0] count_q;
  logic [CntWidth:0]   occupancy;
  logic                inflight_q;
  logic                push;
  logic                pop;
  logic                empty;
  logic                store;
  logic                drain;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(BufDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // An SC answers 0 on success and 1 on failure instead of the read data
  assign in_entry.rdata  = sc_q_i ? atop_pkg::data_t'(!lr_sc_ok_q_i) : mem_r_i.rdata;
  assign in_entry.err    = mem_r_i.err;
  assign in_entry.exokay = lr_sc_ok_q_i;
  assign in_entry.rid    = mem_r_i.rid;

  assign push     = mem_rvalid_i & push_i;
  assign empty    = (count_q == '0);
  assign rvalid_o = !empty | push;
  assign r_o      = empty ? in_entry : entries_q[rptr_q];
  assign pop      = rvalid_o & rready_i;

  // A response taken in its arrival cycle bypasses the storage
  assign store = push & !(empty & pop);
  assign drain = pop & !empty;

  assign occupancy = {1'b0, count_q} + (CntWidth + 1)'(inflight_q);
  assign room_o    = occupancy < (CntWidth + 1)'(BufDepth);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q     <= '0;
      rptr_q     <= '0;
      count_q    <= '0;
      inflight_q <= 1'b0;
    end else begin
      if (store) begin
        wptr_q <= next_ptr(wptr_q);
      end
      if (drain) begin
        rptr_q <= next_ptr(rptr_q);
      end
      count_q <= count_q + CntWidth'(store) - CntWidth'(drain);
      if (issue_i) begin
        inflight_q <= 1'b1;
      end else if (mem_rvalid_i) begin
        inflight_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (store) begin
      entries_q[wptr_q] <= in_entry;
    end
  end

endmodule
